//--- mempool.f
mempool_pkg.sv
tcdm_bank.sv
mempool_tile.sv
rr_arbiter.sv
tcdm_xbar.sv
mempool.sv
mempool_chk.sv
tb_mempool.sv

//--- mempool.sv
// Shared-memory cluster top level
// Four core ports reach two tiles of TCDM banks through a full crossbar
`timescale 1ns/100ps

module mempool import mempool_pkg::*; (
  // Clock and reset
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Core ports
  input  logic      [NumCores-1:0] req_i,
  input  tcdm_req_t [NumCores-1:0] core_req_i,
  output logic      [NumCores-1:0] gnt_o,
  output logic      [NumCores-1:0] rvalid_o,
  output data_t     [NumCores-1:0] rdata_o
);

  // Bank ports between crossbar and tiles
  logic       [NumBanks-1:0] bank_req;
  bank_req_t  [NumBanks-1:0] bank_req_data;
  logic       [NumBanks-1:0] bank_rvalid;
  bank_resp_t [NumBanks-1:0] bank_resp;

  tcdm_xbar u_xbar (
    .clk_i           (clk_i        ),
    .rst_n_i         (rst_n_i      ),
    .req_i           (req_i        ),
    .core_req_i      (core_req_i   ),
    .gnt_o           (gnt_o        ),
    .rvalid_o        (rvalid_o     ),
    .rdata_o         (rdata_o      ),
    .bank_req_o      (bank_req     ),
    .bank_req_data_o (bank_req_data),
    .bank_rvalid_i   (bank_rvalid  ),
    .bank_resp_i     (bank_resp    )
  );

  // Tile t owns global banks t*NumBanksPerTile and up
  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    mempool_tile u_tile (
      .clk_i          (clk_i                                               ),
      .rst_n_i        (rst_n_i                                             ),
      .mem_req_i      (bank_req[NumBanksPerTile*t +: NumBanksPerTile]      ),
      .mem_req_data_i (bank_req_data[NumBanksPerTile*t +: NumBanksPerTile] ),
      .mem_rvalid_o   (bank_rvalid[NumBanksPerTile*t +: NumBanksPerTile]   ),
      .mem_resp_o     (bank_resp[NumBanksPerTile*t +: NumBanksPerTile]     )
    );
  end : gen_tiles

endmodule : mempool

//--- mempool_chk.sv
// Protocol checker for the core-side strobes of the cluster
// Bound into the top level, flags grant and response timing errors
`timescale 1ns/100ps

module mempool_chk import mempool_pkg::*; (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic [NumCores-1:0] req_i,
  input logic [NumCores-1:0] gnt_i,
  input logic [NumCores-1:0] rvalid_i
);

  // Failed assertions, read back by the testbench at the end
  int unsigned fail_cnt = 0;

  // Response one cycle after each grant, and never otherwise
  for (genvar c = 0; c < NumCores; c++) begin : gen_core
    a_rvalid_after_gnt : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) rvalid_i[c] == $past(gnt_i[c])
    ) else begin
      $error("core %0d response strobe does not follow its grant", c);
      fail_cnt++;
    end
  end : gen_core

  a_gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (gnt_i & ~req_i) == '0
  ) else begin
    $error("grant given to a core without a request");
    fail_cnt++;
  end

  a_rvalid_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(rvalid_i)
  ) else begin
    $error("response strobe is unknown after reset");
    fail_cnt++;
  end

endmodule : mempool_chk

bind mempool mempool_chk u_chk (
  .clk_i    (clk_i   ),
  .rst_n_i  (rst_n_i ),
  .req_i    (req_i   ),
  .gnt_i    (gnt_o   ),
  .rvalid_i (rvalid_o)
);

//--- mempool_pkg.sv
// Shared sizes, address fields and TCDM transfer structs for the
// reduced shared-memory cluster
package mempool_pkg;

  // Cluster sizes
  localparam int unsigned NumCores        = 4;
  localparam int unsigned NumTiles        = 2;
  localparam int unsigned NumBanksPerTile = 2;
  localparam int unsigned NumBanks        = NumTiles * NumBanksPerTile;

  // Word and address geometry
  localparam int unsigned DataWidth       = 32;
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned BeWidth         = DataWidth / 8;
  localparam int unsigned TCDMSizePerBank = 256;
  localparam int unsigned NumWordsPerBank = TCDMSizePerBank / BeWidth;
  localparam int unsigned RowWidth        = $clog2(NumWordsPerBank);
  localparam int unsigned BankSelWidth    = $clog2(NumBanks);
  localparam int unsigned CoreIdWidth     = $clog2(NumCores);

  // Address fields: byte offset, then bank index, then row
  localparam int unsigned ByteOffWidth    = $clog2(BeWidth);
  localparam int unsigned BankSelLsb      = ByteOffWidth;
  localparam int unsigned RowLsb          = BankSelLsb + BankSelWidth;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     strb_t;
  typedef logic [CoreIdWidth-1:0] core_id_t;
  typedef logic [RowWidth-1:0]    row_t;

  // Core-side request
  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
    strb_t be;
  } tcdm_req_t;

  // Request as seen by one bank
  typedef struct packed {
    core_id_t ini;
    row_t     row;
    logic     wen;
    data_t    wdata;
    strb_t    be;
  } bank_req_t;

  // Bank response, tagged with the initiator
  typedef struct packed {
    core_id_t ini;
    data_t    rdata;
  } bank_resp_t;

endpackage : mempool_pkg

//--- mempool_tile.sv
// Cluster tile holding its share of the TCDM banks
// Exposes one bank-side port per bank towards the crossbar
`timescale 1ns/100ps

module mempool_tile import mempool_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic       [NumBanksPerTile-1:0] mem_req_i,
  input  bank_req_t  [NumBanksPerTile-1:0] mem_req_data_i,
  output logic       [NumBanksPerTile-1:0] mem_rvalid_o,
  output bank_resp_t [NumBanksPerTile-1:0] mem_resp_o
);

  // Bank size must split evenly into rows of whole words
  if (TCDMSizePerBank != (2**RowWidth) * BeWidth) begin : gen_bank_rows_check
    $fatal(1, "[mempool_tile] Bank size does not divide into a power-of-two number of words.");
  end

  // Bank index is taken from a power-of-two address field
  if (NumBanks != 2**BankSelWidth) begin : gen_bank_pow2_check
    $fatal(1, "[mempool_tile] The number of banks must be a power of two.");
  end

  if (NumCores != 2**CoreIdWidth) begin : gen_core_pow2_check
    $fatal(1, "[mempool_tile] The number of cores must be a power of two.");
  end

  for (genvar b = 0; b < NumBanksPerTile; b++) begin : gen_banks
    tcdm_bank u_bank (
      .clk_i      (clk_i            ),
      .rst_n_i    (rst_n_i          ),
      .req_i      (mem_req_i[b]     ),
      .req_data_i (mem_req_data_i[b]),
      .rvalid_o   (mem_rvalid_o[b]  ),
      .resp_o     (mem_resp_o[b]    )
    );
  end : gen_banks

endmodule : mempool_tile

//--- rr_arbiter.sv
// Round-robin arbiter over the core ports of one bank
// Search starts at the core after the last one granted
`timescale 1ns/100ps

module rr_arbiter import mempool_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NumCores-1:0] req_i,
  output logic [NumCores-1:0] gnt_o,
  output core_id_t            idx_o
);

  core_id_t last_q;
  core_id_t cand;
  logic     found;

  always_comb begin
    gnt_o = '0;
    idx_o = last_q;
    found = 1'b0;
    cand  = last_q;
    // Walk once around the ring, ending on the last winner
    for (int unsigned i = 1; i <= NumCores; i++) begin
      cand = core_id_t'((last_q + i) % NumCores);
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        idx_o       = cand;
        gnt_o[cand] = 1'b1;
      end
    end
  end

  // Core 0 has first priority out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q <= core_id_t'(NumCores - 1);
    end else if (|gnt_o) begin
      last_q <= idx_o;
    end
  end

endmodule : rr_arbiter

//--- tb_mempool.sv
// Testbench for the shared-memory cluster
// Per-core request queues, a word model of the TCDM and response checking
`timescale 1ns/100ps

module tb_mempool import mempool_pkg::*; ();

  logic                     clk_i;
  logic                     rst_n_i;
  logic      [NumCores-1:0] req_i;
  tcdm_req_t [NumCores-1:0] core_req_i;
  logic      [NumCores-1:0] gnt_o;
  logic      [NumCores-1:0] rvalid_o;
  data_t     [NumCores-1:0] rdata_o;

  string         test_name;
  int unsigned   mismatch_errs;
  int unsigned   proto_errs;
  int unsigned   timeout_errs;
  logic          rand_mode;
  logic [31:0]   lfsr_q = 32'hc138;
  // Grant vector sampled mid-cycle, used at the next rising edge
  logic [NumCores-1:0] gnt_s;

  data_t     model_mem [256];
  tcdm_req_t pend_q [NumCores][$];
  data_t     exp_q  [NumCores][$];

  mempool u_dut (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .req_i      (req_i     ),
    .core_req_i (core_req_i),
    .gnt_o      (gnt_o     ),
    .rvalid_o   (rvalid_o  ),
    .rdata_o    (rdata_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Word index is address bits 9 to 2; writes merge bytes and answer zero
  function automatic data_t ref_access(input addr_t addr, input logic wen,
                                       input strb_t be, input data_t wdata);
    logic [7:0] idx;
    data_t      word;
    idx  = addr[9:2];
    word = model_mem[idx];
    if (!wen) begin
      return word;
    end
    for (int unsigned b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    model_mem[idx] = word;
    return '0;
  endfunction

  // Fill pattern mixes every address bit
  function automatic data_t fill_word(input addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c138;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_strobe(input string name, input logic [NumCores-1:0] exp,
                              input logic [NumCores-1:0] act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic push_req(input int unsigned core, input addr_t addr, input logic wen,
                          input data_t wdata, input strb_t be);
    tcdm_req_t r;
    r.addr  = addr;
    r.wen   = wen;
    r.wdata = wdata;
    r.be    = be;
    pend_q[core].push_back(r);
  endtask

  // Wait until every core has drained its queue and seen all responses
  task automatic wait_idle(input int unsigned max_cycles);
    int unsigned         n;
    logic [NumCores-1:0] busy;
    n    = 0;
    busy = '1;
    while (busy != '0 && n < max_cycles) begin
      @(negedge clk_i);
      n++;
      for (int unsigned c = 0; c < NumCores; c++) begin
        busy[c] = pend_q[c].size() != 0 || req_i[c] || exp_q[c].size() != 0;
      end
    end
    for (int unsigned c = 0; c < NumCores; c++) begin
      if (busy[c]) begin
        timeout_errs++;
        $display("timeout: core %0d did not finish its requests in test %s", c, test_name);
      end
    end
  endtask

  // Core c takes a word of a different bank; all must go in one cycle
  task automatic parallel_burst(input addr_t base, input logic wen);
    for (int unsigned c = 0; c < NumCores; c++) begin
      push_req(c, base + addr_t'(4 * ((c + 1) % NumCores)), wen, rand_bits(32), 4'hf);
    end
    @(negedge clk_i);
    check_strobe({test_name, " gnt"}, '1, gnt_o);
    @(negedge clk_i);
    check_strobe({test_name, " rvalid"}, '1, rvalid_o);
    wait_idle(20);
  endtask

  // Driver: record granted requests, then present the next one
  always @(posedge clk_i) begin : drive_cores
    logic holding;
    logic take;
    for (int unsigned c = 0; c < NumCores; c++) begin
      if (req_i[c] && gnt_s[c]) begin
        exp_q[c].push_back(ref_access(core_req_i[c].addr, core_req_i[c].wen,
                                      core_req_i[c].be, core_req_i[c].wdata));
        void'(pend_q[c].pop_front());
      end
      holding = req_i[c] && !gnt_s[c];
      if (!holding) begin
        take = pend_q[c].size() != 0;
        if (take && rand_mode) begin
          take = rand_bits(1) == 1;
        end
        if (take) begin
          req_i[c]      <= 1'b1;
          core_req_i[c] <= pend_q[c][0];
        end else begin
          req_i[c] <= 1'b0;
        end
      end
    end
  end

  // Compare: each response against the oldest expected word of its core
  always @(negedge clk_i) begin : compare_responses
    data_t exp_word;
    gnt_s = gnt_o;
    for (int unsigned c = 0; c < NumCores; c++) begin
      if (rvalid_o[c] === 1'b1) begin
        if (exp_q[c].size() == 0) begin
          proto_errs++;
          $display("core %0d got a response with nothing outstanding in test %s",
                   c, test_name);
        end else begin
          exp_word = exp_q[c].pop_front();
          check_data(test_name, exp_word, rdata_o[c]);
        end
      end
    end
  end

  initial begin : run_tests
    logic [NumCores-1:0] exp_vec;
    int unsigned         core;
    int unsigned         total;
    rst_n_i       = 1'b0;
    req_i         = '0;
    core_req_i    = '0;
    rand_mode     = 1'b0;
    gnt_s         = '0;
    mismatch_errs = 0;
    proto_errs    = 0;
    timeout_errs  = 0;
    test_name     = "reset";

    // Two rising edges under reset, checked in between
    @(posedge clk_i);
    @(negedge clk_i);
    check_strobe("reset gnt", '0, gnt_o);
    check_strobe("reset rvalid", '0, rvalid_o);
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_strobe("after reset gnt", '0, gnt_o);
      check_strobe("after reset rvalid", '0, rvalid_o);
    end

    // All cores on bank 2, fresh pointer gives core 0 first
    test_name = "conflict";
    for (int unsigned c = 0; c < NumCores; c++) begin
      push_req(c, addr_t'(16 * (c + 1) + 8), 1'b1, 32'hc0de_0000 | c, 4'hf);
    end
    for (int unsigned k = 0; k < NumCores; k++) begin
      @(negedge clk_i);
      exp_vec = '0;
      exp_vec[k] = 1'b1;
      check_strobe("conflict gnt", exp_vec, gnt_o);
      exp_vec = '0;
      if (k > 0) begin
        exp_vec[k-1] = 1'b1;
      end
      check_strobe("conflict rvalid", exp_vec, rvalid_o);
    end
    wait_idle(20);

    test_name = "byte merge";
    push_req(1, 32'h0000_0034, 1'b1, 32'h1122_3344, 4'hf);
    push_req(1, 32'h0000_0034, 1'b1, 32'haabb_ccdd, 4'b0101);
    push_req(1, 32'h0000_0034, 1'b0, '0, 4'hf);
    wait_idle(20);
    check_data("byte merge model", 32'h11bb_33dd, model_mem[8'h0d]);

    test_name = "parallel";
    parallel_burst(32'h0000_0300, 1'b1);

    // Alias above bit 9, then four consecutive words read through an alias
    test_name = "wrap";
    push_req(2, 32'h0000_0110, 1'b1, 32'h5eed_0110, 4'hf);
    wait_idle(20);
    push_req(3, 32'habcd_fd10, 1'b0, '0, 4'hf);
    wait_idle(20);
    test_name = "interleave";
    for (int unsigned k = 0; k < NumBanks; k++) begin
      push_req(0, addr_t'(32'h200 + 4 * k), 1'b1, rand_bits(32), 4'hf);
    end
    wait_idle(20);
    parallel_burst(32'h0000_7e00, 1'b0);

    test_name = "fill";
    for (int unsigned w = 0; w < 256; w++) begin
      push_req(w % NumCores, addr_t'(4 * w), 1'b1, fill_word(addr_t'(4 * w)), 4'hf);
    end
    wait_idle(400);

    test_name = "random";
    rand_mode = 1'b1;
    for (int unsigned n = 0; n < 400; n++) begin
      core = rand_bits(CoreIdWidth);
      push_req(core, rand_bits(AddrWidth), 1'(rand_bits(1)), rand_bits(DataWidth),
               strb_t'(rand_bits(BeWidth)));
    end
    wait_idle(5000);
    rand_mode = 1'b0;

    total = mismatch_errs + proto_errs + timeout_errs + u_dut.u_chk.fail_cnt;
    $display("errors: %0d mismatch, %0d protocol, %0d timeout, %0d assertion",
             mismatch_errs, proto_errs, timeout_errs, u_dut.u_chk.fail_cnt);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_mempool

//--- tcdm_bank.sv
// Single-port TCDM bank with byte enables
// Answers one cycle after the request, tagged with the initiator index
`timescale 1ns/100ps

module tcdm_bank import mempool_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  bank_req_t  req_data_i,
  output logic       rvalid_o,
  output bank_resp_t resp_o
);

  data_t    mem_q [NumWordsPerBank];
  logic     rvalid_q;
  core_id_t ini_q;
  data_t    rdata_q;

  // Storage, written byte by byte
  always_ff @(posedge clk_i) begin
    if (req_i && req_data_i.wen) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (req_data_i.be[b]) begin
          mem_q[req_data_i.row][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Response valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  // Response payload; read sees the word from before this edge's write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      ini_q <= req_data_i.ini;
      if (req_data_i.wen) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[req_data_i.row];
      end
    end
  end

  assign rvalid_o     = rvalid_q;
  assign resp_o.ini   = ini_q;
  assign resp_o.rdata = rdata_q;

endmodule : tcdm_bank

//--- tcdm_xbar.sv
// Full crossbar between the core ports and the TCDM banks
// Per-bank round-robin arbitration, responses routed back by initiator index
`timescale 1ns/100ps

module tcdm_xbar import mempool_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Core side
  input  logic       [NumCores-1:0] req_i,
  input  tcdm_req_t  [NumCores-1:0] core_req_i,
  output logic       [NumCores-1:0] gnt_o,
  output logic       [NumCores-1:0] rvalid_o,
  output data_t      [NumCores-1:0] rdata_o,
  // Bank side
  output logic       [NumBanks-1:0] bank_req_o,
  output bank_req_t  [NumBanks-1:0] bank_req_data_o,
  input  logic       [NumBanks-1:0] bank_rvalid_i,
  input  bank_resp_t [NumBanks-1:0] bank_resp_i
);

  logic [NumCores-1:0][BankSelWidth-1:0] bank_sel;
  logic [NumBanks-1:0][NumCores-1:0]     bank_core_req;
  logic [NumBanks-1:0][NumCores-1:0]     bank_gnt;
  core_id_t [NumBanks-1:0]               bank_idx;

  // Per-tile response, steered to cores
  logic  [NumTiles-1:0][NumCores-1:0] tile_rvalid;
  data_t [NumTiles-1:0][NumCores-1:0] tile_rdata;

  // Bank decode
  for (genvar c = 0; c < NumCores; c++) begin : gen_decode
    assign bank_sel[c] = core_req_i[c].addr[BankSelLsb +: BankSelWidth];
    for (genvar b = 0; b < NumBanks; b++) begin : gen_req_vec
      assign bank_core_req[b][c] = req_i[c] && (bank_sel[c] == BankSelWidth'(b));
    end : gen_req_vec
  end : gen_decode

  // One arbiter per bank, winner forwarded with its row and index
  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    rr_arbiter u_arb (
      .clk_i   (clk_i           ),
      .rst_n_i (rst_n_i         ),
      .req_i   (bank_core_req[b]),
      .gnt_o   (bank_gnt[b]     ),
      .idx_o   (bank_idx[b]     )
    );

    assign bank_req_o[b]            = |bank_core_req[b];
    assign bank_req_data_o[b].ini   = bank_idx[b];
    assign bank_req_data_o[b].row   = core_req_i[bank_idx[b]].addr[RowLsb +: RowWidth];
    assign bank_req_data_o[b].wen   = core_req_i[bank_idx[b]].wen;
    assign bank_req_data_o[b].wdata = core_req_i[bank_idx[b]].wdata;
    assign bank_req_data_o[b].be    = core_req_i[bank_idx[b]].be;
  end : gen_banks

  // A core requests one bank at a time, so at most one grant is set
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      gnt_o = gnt_o | bank_gnt[b];
    end
  end

  // Return path inside each tile
  always_comb begin
    tile_rvalid = '0;
    tile_rdata  = '0;
    for (int unsigned t = 0; t < NumTiles; t++) begin
      for (int unsigned lb = 0; lb < NumBanksPerTile; lb++) begin
        if (bank_rvalid_i[t*NumBanksPerTile + lb]) begin
          tile_rvalid[t][bank_resp_i[t*NumBanksPerTile + lb].ini] = 1'b1;
          tile_rdata[t][bank_resp_i[t*NumBanksPerTile + lb].ini] =
            bank_resp_i[t*NumBanksPerTile + lb].rdata;
        end
      end
    end
  end

  // Merge the tiles; fixed bank latency keeps one response per core
  always_comb begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int unsigned c = 0; c < NumCores; c++) begin
      for (int unsigned t = 0; t < NumTiles; t++) begin
        if (tile_rvalid[t][c]) begin
          rvalid_o[c] = 1'b1;
          rdata_o[c]  = rdata_o[c] | tile_rdata[t][c];
        end
      end
    end
  end

endmodule : tcdm_xbar
